/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f scope.f --top-module scope_tb
	./obj_dir/Vscope_tb | tee /dev/stderr | grep -q "All tests passed"

clean:
	rm -rf obj_dir

/* rtl/acq_trigger.sv */
//--------------------------------------
// acquisition FSM: writes the circular buffer at the
// downsampled rate, finds the trigger, counts post samples
//--------------------------------------
`timescale 1ns/1ps

module acq_trigger (
	input  logic                                 clk,
	input  logic                                 rstn,
	input  logic signed [scope_pkg::SAMPLE_W-1:0] i_sample,
	input  scope_pkg::acq_cfg_t                  i_cfg,
	input  logic                                 i_arm,
	input  logic                                 i_readout_done,
	output scope_pkg::acq_status_t               o_status,
	output logic                                 o_wr,
	output logic [scope_pkg::ADDR_W-1:0]         o_wr_addr,
	output logic [scope_pkg::SAMPLE_W-1:0]       o_wr_data
);

	scope_pkg::acq_state_e        state;
	logic [31:0]                  ds_cnt;    // counts 1 .. 2^exp
	logic                         tick;      // write this sample
	logic [scope_pkg::ADDR_W-1:0] wr_addr;
	logic [scope_pkg::ADDR_W-1:0] trig_addr;
	logic [15:0]                  event_cnt;
	logic [15:0]                  post_cnt;
	logic [7:0]                   tot_cnt;

	assign tick = (state != scope_pkg::ACQ_HELD) && ds_cnt[i_cfg.ds_exp];

	assign o_status.event_cnt = event_cnt;
	assign o_status.post_cnt  = post_cnt;
	assign o_status.trig_addr = trig_addr;
	assign o_status.held      = (state == scope_pkg::ACQ_HELD);

	//--------------------------------------
	// buffer write side
	//--------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			ds_cnt  <= 32'd1;
			wr_addr <= '0;
			o_wr    <= 1'b0;
		end else begin
			o_wr <= tick;
			if (state == scope_pkg::ACQ_HELD || tick) ds_cnt <= 32'd1;
			else ds_cnt <= ds_cnt + 32'd1;
			if (tick) wr_addr <= wr_addr + 1'b1; // wraps at DEPTH
		end
	end

	always_ff @(posedge clk) begin
		o_wr_addr <= wr_addr;
		o_wr_data <= i_sample;
	end

	//--------------------------------------
	// trigger FSM
	//--------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state     <= scope_pkg::ACQ_READY;
			trig_addr <= '0;
			event_cnt <= '0;
			post_cnt  <= '0;
			tot_cnt   <= '0;
		end else begin
			case (state)
				scope_pkg::ACQ_READY: begin
					post_cnt <= '0;
					tot_cnt  <= '0;
					if (i_arm) begin
						case (i_cfg.trig_type)
							scope_pkg::TRIG_FALL: state <= scope_pkg::ACQ_FALL_FIRST;
							scope_pkg::TRIG_RISE: state <= scope_pkg::ACQ_RISE_FIRST;
							default: begin // no trigger, take data at once
								trig_addr <= wr_addr;
								state     <= scope_pkg::ACQ_POST;
							end
						endcase
					end
				end
				scope_pkg::ACQ_FALL_FIRST:
					if (i_sample < i_cfg.lower) state <= scope_pkg::ACQ_FALL_SECOND;
				scope_pkg::ACQ_FALL_SECOND: if (i_sample > i_cfg.upper) begin
					tot_cnt <= tot_cnt + 8'd1;
					if (tot_cnt >= i_cfg.tot) begin
						trig_addr <= wr_addr;
						state     <= scope_pkg::ACQ_POST;
					end
				end
				scope_pkg::ACQ_RISE_FIRST:
					if (i_sample > i_cfg.upper) state <= scope_pkg::ACQ_RISE_SECOND;
				scope_pkg::ACQ_RISE_SECOND: if (i_sample < i_cfg.lower) begin
					tot_cnt <= tot_cnt + 8'd1;
					if (tot_cnt >= i_cfg.tot) begin
						trig_addr <= wr_addr;
						state     <= scope_pkg::ACQ_POST;
					end
				end
				scope_pkg::ACQ_POST: begin
					if (post_cnt < i_cfg.post_len) begin
						if (tick) post_cnt <= post_cnt + 16'd1;
					end else begin
						event_cnt <= event_cnt + 16'd1;
						post_cnt  <= 16'hffff; // flags a held event
						state     <= scope_pkg::ACQ_HELD;
					end
				end
				scope_pkg::ACQ_HELD: if (i_readout_done) begin
					post_cnt <= '0;
					state    <= scope_pkg::ACQ_READY;
				end
				default: state <= scope_pkg::ACQ_READY;
			endcase
		end
	end

endmodule

/* rtl/cmd_controller.sv */
//--------------------------------------
// decodes commands, keeps the acquisition settings,
// walks the buffer for readout and loads reply words
//--------------------------------------
`timescale 1ns/1ps

module cmd_controller (
	input  logic                                clk,
	input  logic                                rstn,
	input  logic                                i_cmd_valid,
	input  scope_pkg::cmd_t                     i_cmd,
	output logic                                o_cmd_done,
	output scope_pkg::acq_cfg_t                 o_cfg,
	output logic                                o_arm,
	output logic                                o_readout_done,
	input  scope_pkg::acq_status_t              i_status,
	output logic                                o_rd_req,
	output logic [scope_pkg::ADDR_W-1:0]        o_rd_addr,
	input  logic                                i_rd_gnt,
	input  logic [scope_pkg::SAMPLE_W-1:0]      i_rd_data,
	output logic                                o_reply_load,
	output scope_pkg::reply_t                   o_reply,
	input  logic                                i_reply_busy,
	input  logic                                i_word_taken
);

	typedef enum logic [2:0] {
		CS_IDLE,
		CS_REPLY,
		CS_RD_REQ,
		CS_RD_DATA,
		CS_RD_TAKE
	} ctl_state_e;

	ctl_state_e                     state;
	logic [scope_pkg::ADDR_W-1:0]   preoffset;
	logic [31:0]                    remain;     // readout bytes left
	logic [15:0]                    rd_len;
	logic [scope_pkg::SAMPLE_W-1:0] b1_w;
	logic [scope_pkg::SAMPLE_W-1:0] b2_w;
	logic [scope_pkg::SAMPLE_W-1:0] lower_calc;
	logic [scope_pkg::SAMPLE_W-1:0] upper_calc;

	//--------------------------------------
	// threshold arithmetic, 12 bit wraparound
	//--------------------------------------
	assign b1_w = {{(scope_pkg::SAMPLE_W-8){1'b0}}, i_cmd.b1};
	assign b2_w = {{(scope_pkg::SAMPLE_W-8){1'b0}}, i_cmd.b2};
	assign lower_calc = ((b1_w - b2_w - 12'd128) << 4) + 12'd8;
	assign upper_calc = ((b1_w + b2_w - 12'd128) << 4) + 12'd8;

	assign rd_len = (remain > 32'h0000_ffff) ? 16'hffff : remain[15:0]; // saturate

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state          <= CS_IDLE;
			o_cfg          <= '0;
			preoffset      <= '0;
			remain         <= '0;
			o_rd_req       <= 1'b0;
			o_rd_addr      <= '0;
			o_arm          <= 1'b0;
			o_readout_done <= 1'b0;
			o_cmd_done     <= 1'b0;
			o_reply_load   <= 1'b0;
		end else begin
			o_arm          <= 1'b0;
			o_readout_done <= 1'b0;
			o_cmd_done     <= 1'b0;
			o_reply_load   <= 1'b0;
			case (state)
				CS_IDLE: if (i_cmd_valid) begin
					case (i_cmd.op)
						scope_pkg::CMD_READOUT: begin
							remain    <= {i_cmd.b7, i_cmd.b6, i_cmd.b5, i_cmd.b4};
							o_rd_addr <= i_status.trig_addr - preoffset; // look back before trigger
							o_rd_req  <= 1'b1;
							state     <= CS_RD_REQ;
						end
						scope_pkg::CMD_ARM: begin
							o_cfg.trig_type <= scope_pkg::trig_type_e'(i_cmd.b1);
							o_cfg.post_len  <= {i_cmd.b5, i_cmd.b4};
							if (!i_status.held && i_status.post_cnt == 16'd0) begin
								o_arm <= 1'b1; // only when no event pending
							end
							o_reply      <= '{data: {i_status.event_cnt, i_status.post_cnt},
							                  len: 16'd4};
							o_reply_load <= 1'b1;
							state        <= CS_REPLY;
						end
						scope_pkg::CMD_INFO: begin
							o_reply      <= '{data: scope_pkg::VERSION, len: 16'd4};
							o_reply_load <= 1'b1;
							state        <= CS_REPLY;
						end
						scope_pkg::CMD_TRIG_SET: begin
							o_cfg.lower  <= lower_calc;
							o_cfg.upper  <= upper_calc;
							o_cfg.tot    <= i_cmd.b5;
							preoffset    <= {i_cmd.b3[1:0], i_cmd.b4};
							o_reply      <= '{data: 32'd8, len: 16'd4};
							o_reply_load <= 1'b1;
							state        <= CS_REPLY;
						end
						scope_pkg::CMD_DOWNSAMPLE: begin
							o_cfg.ds_exp <= i_cmd.b1[4:0];
							o_reply      <= '{data: 32'd9, len: 16'd4};
							o_reply_load <= 1'b1;
							state        <= CS_REPLY;
						end
						default: o_cmd_done <= 1'b1; // unknown, drop silently
					endcase
				end
				CS_REPLY: if (!o_reply_load && !i_reply_busy) begin
					o_cmd_done <= 1'b1;
					state      <= CS_IDLE;
				end
				CS_RD_REQ: if (i_rd_gnt) begin
					o_rd_req <= 1'b0;
					state    <= CS_RD_DATA;
				end
				CS_RD_DATA: begin // ram word valid now
					o_reply      <= '{data: {{(scope_pkg::WORD_W-scope_pkg::SAMPLE_W){1'b0}},
					                         i_rd_data}, len: rd_len};
					o_reply_load <= 1'b1;
					state        <= CS_RD_TAKE;
				end
				CS_RD_TAKE: if (i_word_taken) begin
					if (remain <= 32'd4) begin
						o_readout_done <= 1'b1;
						o_cmd_done     <= 1'b1;
						state          <= CS_IDLE;
					end else begin
						remain    <= remain - 32'd4;
						o_rd_addr <= o_rd_addr + 1'b1; // wraps at DEPTH
						o_rd_req  <= 1'b1;
						state     <= CS_RD_REQ;
					end
				end
				default: state <= CS_IDLE;
			endcase
		end
	end

endmodule

/* rtl/cmd_receiver.sv */
//--------------------------------------
// byte stream slave, gathers 8 bytes into one command
// and stalls until the controller has served it
//--------------------------------------
`timescale 1ns/1ps

module cmd_receiver (
	input  logic               clk,
	input  logic               rstn,
	input  logic               i_tvalid,
	input  logic [7:0]         i_tdata,
	output logic               o_tready,
	input  logic               i_cmd_done,
	output logic               o_cmd_valid,
	output scope_pkg::cmd_t    o_cmd
);

	logic [2:0] byte_cnt;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_tready    <= 1'b1;
			o_cmd_valid <= 1'b0;
			byte_cnt    <= 3'd0;
		end else begin
			o_cmd_valid <= 1'b0;
			if (o_tready && i_tvalid) begin
				byte_cnt <= byte_cnt + 3'd1; // wraps to 0 after the 8th
				if (byte_cnt == 3'(scope_pkg::CMD_BYTES - 1)) begin
					o_cmd_valid <= 1'b1;
					o_tready    <= 1'b0; // hold off until served
				end
			end else if (i_cmd_done) begin
				o_tready <= 1'b1;
			end
		end
	end

	// shift in from the top, byte 0 ends up lowest
	always_ff @(posedge clk) begin
		if (o_tready && i_tvalid) begin
			o_cmd <= scope_pkg::cmd_t'({i_tdata, o_cmd[scope_pkg::CMD_BYTES*8-1:8]});
		end
	end

endmodule

/* rtl/reply_stream.sv */
//--------------------------------------
// 32-bit reply stream master, one word per load,
// keep and last derived from the bytes still owed
//--------------------------------------
`timescale 1ns/1ps

module reply_stream (
	input  logic                             clk,
	input  logic                             rstn,
	input  logic                             i_load,
	input  scope_pkg::reply_t                i_reply,
	output logic                             o_busy,
	output logic                             o_word_taken,
	input  logic                             i_tready,
	output logic                             o_tvalid,
	output logic [scope_pkg::WORD_W-1:0]     o_tdata,
	output logic [3:0]                       o_tkeep,
	output logic                             o_tlast
);

	logic [15:0] remain;

	assign o_busy       = o_tvalid;
	assign o_word_taken = o_tvalid && i_tready;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_tvalid <= 1'b0;
			remain   <= '0;
		end else if (i_load) begin
			o_tvalid <= 1'b1;
			remain   <= i_reply.len;
		end else if (o_word_taken) begin
			o_tvalid <= 1'b0;
			remain   <= (remain >= 16'd4) ? remain - 16'd4 : 16'd0;
		end
	end

	always_ff @(posedge clk) begin
		if (i_load) o_tdata <= i_reply.data; // steady while valid
	end

	always_comb begin
		case (remain)
			16'd0:   o_tkeep = 4'b0000;
			16'd1:   o_tkeep = 4'b0001;
			16'd2:   o_tkeep = 4'b0011;
			16'd3:   o_tkeep = 4'b0111;
			default: o_tkeep = 4'b1111;
		endcase
	end

	assign o_tlast = (remain <= 16'd4);

endmodule

/* rtl/sample_buffer.sv */
//--------------------------------------
// single port sample RAM shared by writer and reader,
// writes always win, reads take the free cycles
//--------------------------------------
`timescale 1ns/1ps

module sample_buffer (
	input  logic                             clk,
	input  logic                             rstn,
	input  logic                             i_wr,
	input  logic [scope_pkg::ADDR_W-1:0]     i_wr_addr,
	input  logic [scope_pkg::SAMPLE_W-1:0]   i_wr_data,
	input  logic                             i_rd_req,
	input  logic [scope_pkg::ADDR_W-1:0]     i_rd_addr,
	output logic                             o_rd_gnt,
	output logic [scope_pkg::SAMPLE_W-1:0]   o_rd_data
);

	logic [scope_pkg::SAMPLE_W-1:0] mem [scope_pkg::DEPTH];

	//--------------------------------------
	// arbiter
	//--------------------------------------
	assign o_rd_gnt = i_rd_req && !i_wr; // reader waits on any write

	//--------------------------------------
	// storage
	//--------------------------------------
	always_ff @(posedge clk) begin
		if (i_wr) begin
			mem[i_wr_addr] <= i_wr_data;
		end
	end

	// one access per cycle, so the read port only fires on a grant
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_rd_data <= '0;
		end else if (o_rd_gnt) begin
			o_rd_data <= mem[i_rd_addr]; // valid the cycle after grant
		end
	end

endmodule

/* rtl/scope_pkg.sv */
//--------------------------------------
// shared widths, opcodes, FSM states and bus structs
// for the scope acquisition core
//--------------------------------------
package scope_pkg;

	localparam int SAMPLE_W  = 12;
	localparam int ADDR_W    = 10;
	localparam int DEPTH     = 1024;
	localparam int WORD_W    = 32;
	localparam int CMD_BYTES = 8;
	localparam logic [WORD_W-1:0] VERSION = 32'd16; // firmware version

	typedef enum logic [7:0] {
		CMD_READOUT    = 8'd0,
		CMD_ARM        = 8'd1,
		CMD_INFO       = 8'd2,
		CMD_TRIG_SET   = 8'd8,
		CMD_DOWNSAMPLE = 8'd9
	} cmd_op_e;

	typedef enum logic [7:0] {
		TRIG_NONE = 8'd0,
		TRIG_FALL = 8'd1,
		TRIG_RISE = 8'd2
	} trig_type_e;

	typedef enum logic [2:0] {
		ACQ_READY,
		ACQ_FALL_FIRST,
		ACQ_FALL_SECOND,
		ACQ_RISE_FIRST,
		ACQ_RISE_SECOND,
		ACQ_POST,
		ACQ_HELD
	} acq_state_e;

	// byte 0 sits in the low bits, first on the wire
	typedef struct packed {
		logic [7:0] b7;
		logic [7:0] b6;
		logic [7:0] b5;
		logic [7:0] b4;
		logic [7:0] b3;
		logic [7:0] b2;
		logic [7:0] b1;
		cmd_op_e    op;
	} cmd_t;

	typedef struct packed {
		trig_type_e                 trig_type;
		logic signed [SAMPLE_W-1:0] lower;
		logic signed [SAMPLE_W-1:0] upper;
		logic [7:0]                 tot;
		logic [15:0]                post_len;
		logic [4:0]                 ds_exp;
	} acq_cfg_t;

	typedef struct packed {
		logic [15:0]       event_cnt;
		logic [15:0]       post_cnt;
		logic [ADDR_W-1:0] trig_addr;
		logic              held;
	} acq_status_t;

	typedef struct packed {
		logic [WORD_W-1:0] data;
		logic [15:0]       len;  // bytes still to send
	} reply_t;

endpackage

/* rtl/scope_top.sv */
//--------------------------------------
// scope core top: command path, acquisition writer and
// readout reader around one shared sample buffer
//--------------------------------------
`timescale 1ns/1ps

module scope_top (
	input  logic                                 clk,
	input  logic                                 rstn,
	input  logic                                 i_tvalid,
	input  logic [7:0]                           i_tdata,
	output logic                                 o_tready,
	input  logic signed [scope_pkg::SAMPLE_W-1:0] i_sample,
	input  logic                                 i_out_tready,
	output logic                                 o_out_tvalid,
	output logic [scope_pkg::WORD_W-1:0]         o_out_tdata,
	output logic [3:0]                           o_out_tkeep,
	output logic                                 o_out_tlast
);

	scope_pkg::cmd_t                cmd;
	scope_pkg::acq_cfg_t            cfg;
	scope_pkg::acq_status_t         status;
	scope_pkg::reply_t              reply;
	logic                           cmd_valid, cmd_done;
	logic                           arm, readout_done;
	logic                           wr, rd_req, rd_gnt;
	logic [scope_pkg::ADDR_W-1:0]   wr_addr, rd_addr;
	logic [scope_pkg::SAMPLE_W-1:0] wr_data, rd_data;
	logic                           reply_load, reply_busy, word_taken;

	cmd_receiver u_rx (
		.clk, .rstn, .i_tvalid, .i_tdata, .o_tready,
		.i_cmd_done(cmd_done), .o_cmd_valid(cmd_valid), .o_cmd(cmd)
	);

	cmd_controller u_ctl (
		.clk, .rstn, .i_cmd_valid(cmd_valid), .i_cmd(cmd), .o_cmd_done(cmd_done),
		.o_cfg(cfg), .o_arm(arm), .o_readout_done(readout_done), .i_status(status),
		.o_rd_req(rd_req), .o_rd_addr(rd_addr), .i_rd_gnt(rd_gnt), .i_rd_data(rd_data),
		.o_reply_load(reply_load), .o_reply(reply), .i_reply_busy(reply_busy),
		.i_word_taken(word_taken)
	);

	acq_trigger u_acq (
		.clk, .rstn, .i_sample, .i_cfg(cfg), .i_arm(arm), .i_readout_done(readout_done),
		.o_status(status), .o_wr(wr), .o_wr_addr(wr_addr), .o_wr_data(wr_data)
	);

	sample_buffer u_buf (
		.clk, .rstn, .i_wr(wr), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
		.i_rd_req(rd_req), .i_rd_addr(rd_addr), .o_rd_gnt(rd_gnt), .o_rd_data(rd_data)
	);

	reply_stream u_tx (
		.clk, .rstn, .i_load(reply_load), .i_reply(reply), .o_busy(reply_busy),
		.o_word_taken(word_taken), .i_tready(i_out_tready), .o_tvalid(o_out_tvalid),
		.o_tdata(o_out_tdata), .o_tkeep(o_out_tkeep), .o_tlast(o_out_tlast)
	);

endmodule

/* scope.f */
rtl/scope_pkg.sv
rtl/cmd_receiver.sv
rtl/cmd_controller.sv
rtl/acq_trigger.sv
rtl/sample_buffer.sv
rtl/reply_stream.sv
rtl/scope_top.sv
verif/scope_assert.sv
verif/scope_tb.sv

/* verif/scope_assert.sv */
//--------------------------------------
// stream and arbiter rules of the scope core,
// bound into scope_top
//--------------------------------------
`timescale 1ns/1ps

module scope_assert (
	input logic                         clk,
	input logic                         rstn,
	input logic                         i_tvalid,
	input logic                         i_tready,
	input logic [scope_pkg::WORD_W-1:0] i_tdata,
	input logic [3:0]                   i_tkeep,
	input logic                         i_tlast,
	input logic                         i_wr,
	input logic                         i_rd_gnt
);

	// held beat keeps its contents until taken
	assert property (@(posedge clk) disable iff (!rstn)
		i_tvalid && !i_tready |=> i_tvalid && $stable(i_tdata) && $stable(i_tkeep)
		&& $stable(i_tlast))
	else $error("reply beat changed while waiting for ready");

	assert property (@(posedge clk) disable iff (!rstn) !(i_wr && i_rd_gnt))
	else $error("write and read grant in the same cycle");

	assert property (@(posedge clk) disable iff (!rstn)
		i_tvalid && !i_tlast |-> i_tkeep == 4'b1111)
	else $error("partial keep on a beat that is not last");

endmodule

bind scope_top scope_assert u_assert (
	.clk, .rstn, .i_tvalid(o_out_tvalid), .i_tready(i_out_tready), .i_tdata(o_out_tdata),
	.i_tkeep(o_out_tkeep), .i_tlast(o_out_tlast), .i_wr(wr), .i_rd_gnt(rd_gnt)
);

/* verif/scope_tb.sv */
//--------------------------------------
// testbench for the scope core, drives random samples and
// back-pressure and checks replies against a cycle model
//--------------------------------------
`timescale 1ns/1ps

module scope_tb;

	localparam int FILL_MAX    = 1100 << 2;  // fills the buffer at exponent 2
	localparam int MAX_POLLS   = 300;
	localparam int POLL_CYCLES = 60;         // one arm poll with its gap
	localparam int N_EVENTS    = 4;
	localparam int LIMIT       = N_EVENTS * (FILL_MAX + MAX_POLLS * POLL_CYCLES) + 5000;

	logic                                  clk;
	logic                                  rstn;
	logic                                  i_tvalid;
	logic [7:0]                            i_tdata;
	logic                                  o_tready;
	logic signed [scope_pkg::SAMPLE_W-1:0] i_sample;
	logic                                  i_out_tready;
	logic                                  o_out_tvalid;
	logic [scope_pkg::WORD_W-1:0]          o_out_tdata;
	logic [3:0]                            o_out_tkeep;
	logic                                  o_out_tlast;

	// model of the acquisition side
	scope_pkg::acq_state_e                 m_state;
	logic [31:0]                           m_ds;
	logic [scope_pkg::ADDR_W-1:0]          m_waddr, m_trig, m_preoff;
	logic [15:0]                           m_event, m_post, m_post_len;
	logic [7:0]                            m_tot_cnt, m_tot, m_type;
	logic signed [scope_pkg::SAMPLE_W-1:0] m_lower, m_upper;
	logic [4:0]                            m_exp;
	logic [scope_pkg::SAMPLE_W-1:0]        m_ram [scope_pkg::DEPTH];
	logic [63:0]                           rx_cmd, pend_cmd;
	int                                    byte_idx, apply_dly, cycles;
	logic                                  pend_arm_ok, rdone_pend, in_readout;
	logic [31:0]                           q_data[$];
	logic [3:0]                            q_keep[$];
	logic                                  q_last[$];
	logic [31:0]                           q_arm_exp[$];  // predicted arm replies

	scope_top dut0 (
		.clk, .rstn, .i_tvalid, .i_tdata, .o_tready, .i_sample, .i_out_tready,
		.o_out_tvalid, .o_out_tdata, .o_out_tkeep, .o_out_tlast
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		#1;
		i_sample     <= $urandom;
		i_out_tready <= ($urandom % 4) != 0; // random back-pressure
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", LIMIT);
			$display("Some tests failed");
			$fatal(1);
		end
	end

	//--------------------------------------
	// reference model stepped on every edge
	//--------------------------------------
	always @(posedge clk) begin : model
		logic tick;
		logic arm_now;
		int   th;
		if (!rstn) begin
			m_state = scope_pkg::ACQ_READY;
			m_ds = 32'd1;
			m_waddr = '0;
			m_trig = '0;
			m_preoff = '0;
			m_event = '0;
			m_post = '0;
			m_post_len = '0;
			m_tot_cnt = '0;
			m_tot = '0;
			m_type = '0;
			m_lower = '0;
			m_upper = '0;
			m_exp = '0;
			byte_idx = 0;
			apply_dly = 0;
			rdone_pend = 0;
			in_readout = 0;
		end else begin
			arm_now = 1'b0;
			if (apply_dly == 1) begin // settings reach the writer now
				case (pend_cmd[7:0])
					8'h01: begin
						m_type = pend_cmd[15:8];
						m_post_len = pend_cmd[47:32];
						arm_now = pend_arm_ok;
					end
					8'h08: begin
						th = (int'(pend_cmd[15:8]) - int'(pend_cmd[23:16]) - 128) * 16 + 8;
						m_lower = th[11:0];
						th = (int'(pend_cmd[15:8]) + int'(pend_cmd[23:16]) - 128) * 16 + 8;
						m_upper = th[11:0];
						m_tot = pend_cmd[47:40];
						m_preoff = {pend_cmd[25:24], pend_cmd[39:32]};
					end
					8'h09: m_exp = pend_cmd[12:8];
					default: ;
				endcase
			end
			tick = (m_state != scope_pkg::ACQ_HELD) && m_ds[m_exp];
			// counter follows the state before this edge
			if (m_state == scope_pkg::ACQ_HELD || tick) m_ds = 32'd1;
			else m_ds = m_ds + 32'd1;
			case (m_state)
				scope_pkg::ACQ_READY: begin
					m_post = '0;
					m_tot_cnt = '0;
					if (arm_now) begin
						if (m_type == 8'd1) m_state = scope_pkg::ACQ_FALL_FIRST;
						else if (m_type == 8'd2) m_state = scope_pkg::ACQ_RISE_FIRST;
						else begin
							m_trig = m_waddr;
							m_state = scope_pkg::ACQ_POST;
						end
					end
				end
				scope_pkg::ACQ_FALL_FIRST:
					if (i_sample < m_lower) m_state = scope_pkg::ACQ_FALL_SECOND;
				scope_pkg::ACQ_FALL_SECOND: if (i_sample > m_upper) begin
					if (m_tot_cnt >= m_tot) begin
						m_trig = m_waddr;
						m_state = scope_pkg::ACQ_POST;
					end
					m_tot_cnt = m_tot_cnt + 8'd1;
				end
				scope_pkg::ACQ_RISE_FIRST:
					if (i_sample > m_upper) m_state = scope_pkg::ACQ_RISE_SECOND;
				scope_pkg::ACQ_RISE_SECOND: if (i_sample < m_lower) begin
					if (m_tot_cnt >= m_tot) begin
						m_trig = m_waddr;
						m_state = scope_pkg::ACQ_POST;
					end
					m_tot_cnt = m_tot_cnt + 8'd1;
				end
				scope_pkg::ACQ_POST: begin
					if (m_post < m_post_len) begin
						if (tick) m_post = m_post + 16'd1;
					end else begin
						m_event = m_event + 16'd1;
						m_post = 16'hffff;
						m_state = scope_pkg::ACQ_HELD;
					end
				end
				default: if (rdone_pend) begin // held
					m_post = '0;
					m_state = scope_pkg::ACQ_READY;
				end
			endcase
			rdone_pend = 1'b0;
			if (tick) begin
				m_ram[m_waddr] = i_sample;
				m_waddr = m_waddr + 1'b1;
			end
			if (apply_dly > 0) apply_dly = apply_dly - 1;
			if (o_out_tvalid && i_out_tready) begin
				q_data.push_back(o_out_tdata);
				q_keep.push_back(o_out_tkeep);
				q_last.push_back(o_out_tlast);
				if (in_readout && o_out_tlast) begin
					rdone_pend = 1'b1;
					in_readout = 1'b0;
				end
			end
			if (i_tvalid && o_tready) begin
				rx_cmd[8*byte_idx +: 8] = i_tdata;
				byte_idx = byte_idx + 1;
				if (byte_idx == scope_pkg::CMD_BYTES) begin
					byte_idx = 0;
					pend_cmd = rx_cmd;
					apply_dly = 2;
					pend_arm_ok = (m_state != scope_pkg::ACQ_HELD) && (m_post == 16'd0);
					if (rx_cmd[7:0] == 8'h01) q_arm_exp.push_back({m_event, m_post});
					if (rx_cmd[7:0] == 8'h00) in_readout = 1'b1;
				end
			end
		end
	end

	//--------------------------------------
	// stimulus and check tasks
	//--------------------------------------
	task automatic report_mismatch(input string msg);
		$display("ERR %0t: %s", $time, msg);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic idle(input int n);
		repeat (n) next_cycle();
	endtask

	task automatic send_cmd(input logic [63:0] cmd);
		logic accepted;
		for (int i = 0; i < scope_pkg::CMD_BYTES; i++) begin
			i_tvalid = 1'b1;
			i_tdata  = cmd[8*i +: 8];
			accepted = 1'b0;
			while (!accepted) begin
				accepted = o_tready; // stable between edges
				next_cycle();
			end
		end
		i_tvalid = 1'b0;
	endtask

	task automatic take_beat(output logic [31:0] d, output logic [3:0] k, output logic l);
		while (q_data.size() == 0) next_cycle();
		d = q_data.pop_front();
		k = q_keep.pop_front();
		l = q_last.pop_front();
	endtask

	task automatic expect_beat(input logic [31:0] ed, input logic [3:0] ek, input logic el,
	                           input string what);
		logic [31:0] d;
		logic [3:0]  k;
		logic        l;
		take_beat(d, k, l);
		assert (d == ed && k == ek && l == el)
		else report_mismatch($sformatf("%s: got %h keep %b last %b, expected %h %b %b",
		                               what, d, k, l, ed, ek, el));
	endtask

	task automatic trig_set(input logic [7:0] b1, input logic [7:0] b2,
	                        input logic [9:0] preoff, input logic [7:0] tot);
		send_cmd({16'h0, tot, preoff[7:0], 6'h0, preoff[9:8], b2, b1, 8'h08});
		expect_beat(32'd8, 4'hf, 1'b1, "trigger settings");
	endtask

	task automatic downsample(input logic [4:0] ds_exp);
		send_cmd({48'h0, 3'h0, ds_exp, 8'h09});
		expect_beat(32'd9, 4'hf, 1'b1, "downsample");
	endtask

	task automatic arm_cmd(input logic [7:0] ttype, input logic [15:0] plen,
	                       output logic [31:0] status_word);
		logic [3:0] k;
		logic       l;
		send_cmd({16'h0, plen, 16'h0, ttype, 8'h01});
		take_beat(status_word, k, l);
		assert (q_arm_exp.size() > 0) else report_mismatch("arm reply without a command");
		assert (status_word == q_arm_exp[0] && k == 4'hf && l)
		else report_mismatch($sformatf("arm: got %h keep %b last %b, expected %h",
		                               status_word, k, l, q_arm_exp[0]));
		void'(q_arm_exp.pop_front());
	endtask

	// arms, then polls until the post count shows a held event
	task automatic wait_held(input logic [7:0] ttype, input logic [15:0] plen,
	                         output logic [15:0] ev);
		logic [31:0] sw;
		int          polls;
		polls = 0;
		arm_cmd(ttype, plen, sw);
		while (sw[15:0] != 16'hffff) begin
			polls++;
			if (polls >= MAX_POLLS) begin
				$display("no held event after %0d polls", polls);
				$display("Some tests failed");
				$fatal(1);
			end
			idle(20);
			arm_cmd(ttype, plen, sw);
		end
		ev = sw[31:16];
	endtask

	task automatic readout(input logic [15:0] len);
		logic [scope_pkg::ADDR_W-1:0] addr;
		int                           rem;
		assert (m_state == scope_pkg::ACQ_HELD) else report_mismatch("readout without event");
		addr = m_trig - m_preoff;
		send_cmd({16'h0, len, 32'h0});
		for (int w = 0; w * 4 < len; w++) begin
			rem = int'(len) - 4 * w;
			expect_beat({20'h0, m_ram[addr]}, (rem >= 4) ? 4'hf : 4'(4'hf >> (4 - rem)),
			            rem <= 4, $sformatf("readout word %0d", w));
			addr = addr + 1'b1;
		end
	endtask

	//--------------------------------------
	// test sequence
	//--------------------------------------
	initial begin
		logic [15:0] ev;
		logic [31:0] sw;
		logic [4:0]  ds_exp;
		void'($urandom(71));
		cycles       = 0;
		rstn         = 1'b0;
		i_tvalid     = 1'b0;
		i_tdata      = '0;
		i_sample     = '0;
		i_out_tready = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rstn = 1'b1;
		next_cycle();

		repeat (4) begin // version under back-pressure
			send_cmd({56'h0, 8'h02});
			expect_beat(scope_pkg::VERSION, 4'hf, 1'b1, "info");
		end

		trig_set(8'(120 + $urandom % 16), 8'($urandom % 16), 10'($urandom), 8'($urandom % 4));
		downsample(5'd0);
		send_cmd({32'($urandom), 24'($urandom), 8'h55});
		send_cmd({56'h0, 8'h03});
		send_cmd({56'h0, 8'h02});
		expect_beat(scope_pkg::VERSION, 4'hf, 1'b1, "info after unknown opcodes");
		idle(1100);

		wait_held(8'd0, 16'(1 + $urandom % 200), ev);
		assert (ev == 16'd1) else report_mismatch($sformatf("event count %0d after one", ev));
		readout(16'(1 + $urandom % 48));

		for (int t = 1; t <= 2; t++) begin // falling, then rising
			trig_set(8'(120 + $urandom % 16), 8'($urandom % 16), 10'($urandom),
			         8'($urandom % 4));
			ds_exp = 5'($urandom % 3);
			downsample(ds_exp);
			idle(1100 << ds_exp);
			wait_held(8'(t), 16'(1 + $urandom % 200), ev);
			assert (ev == 16'(t + 1)) else report_mismatch($sformatf("event count %0d", ev));
			readout(16'(1 + $urandom % 48));
		end

		arm_cmd(8'd0, 16'd5, sw);
		assert (sw[15:0] == 16'd0) else report_mismatch("arm refused after readout");
		wait_held(8'd0, 16'd5, ev);
		assert (ev == 16'd4) else report_mismatch($sformatf("final event count %0d", ev));

		$display("All tests passed");
		$finish;
	end

endmodule
